/* src/osw_pkg.sv */
package osw_pkg;

    ////////////////////////////////////////
    // switch dimensions
    ////////////////////////////////////////

    // 8x8 fabric, four 2x2 input switches, two 4x4 middle modules
    localparam int NUM_PORTS     = 8;
    localparam int NUM_SWITCHES  = 4;
    localparam int NUM_MID_PORTS = 4;

    localparam int DST_W = 3;
    localparam int MID_W = 2;

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////

    typedef logic [DST_W-1:0] dst_t;
    typedef logic [MID_W-1:0] mid_port_t;

    // input 0 sits in the low field
    typedef logic [NUM_PORTS*DST_W-1:0] req_vec_t;

    // one mode bit per 2x2 switch
    typedef logic [NUM_SWITCHES-1:0] sw_vec_t;

    // one middle port per switch, switch 0 in the low field
    typedef logic [NUM_SWITCHES*MID_W-1:0] mid_req_t;

    ////////////////////////////////////////
    // switch modes
    ////////////////////////////////////////

    // bar: input 2k up, 2k+1 down; cross swaps them
    localparam logic SW_BAR   = 1'b0;
    localparam logic SW_CROSS = 1'b1;

endpackage

/* src/route_table.sv */
`timescale 1ns/1ps

module route_table (
    input  logic                                        i_clk,
    input  logic                                        i_rst,
    input  logic                                        i_capture,
    input  osw_pkg::req_vec_t                           i_req,
    output osw_pkg::req_vec_t                           o_dst,
    output osw_pkg::mid_port_t [osw_pkg::NUM_PORTS-1:0] o_mid_port
);

    ////////////////////////////////////////
    // destination register
    ////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_dst <= '0;
        end else if (i_capture) begin
            o_dst <= i_req;
        end
    end

    ////////////////////////////////////////
    // middle port per input
    ////////////////////////////////////////

    // the middle module port is the destination without its lsb,
    // the lsb only picks the output switch leg
    for (genvar i = 0; i < osw_pkg::NUM_PORTS; i++) begin : g_mid
        osw_pkg::dst_t w_dst;

        assign w_dst         = o_dst[i*osw_pkg::DST_W +: osw_pkg::DST_W];
        assign o_mid_port[i] = w_dst[osw_pkg::DST_W-1 -: osw_pkg::MID_W];
    end

endmodule

/* src/port_arbiter.sv */
`timescale 1ns/1ps

module port_arbiter (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  logic [osw_pkg::NUM_SWITCHES-1:0]  i_req,
    input  logic [osw_pkg::NUM_SWITCHES-1:0]  i_first,
    input  logic                              i_req_valid,
    output logic [osw_pkg::NUM_SWITCHES-1:0]  o_grant,
    output logic                              o_grant_valid
);

    logic [osw_pkg::NUM_SWITCHES-1:0] w_grant;

    // scan upward from the first-priority switch, wrapping
    always_comb begin
        int  v_first;
        int  v_idx;
        logic v_found;

        v_first = 0;
        v_found = 1'b0;
        w_grant = '0;
        for (int k = 0; k < osw_pkg::NUM_SWITCHES; k++) begin
            if (i_first[k]) begin
                v_first = k;
            end
        end
        for (int off = 0; off < osw_pkg::NUM_SWITCHES; off++) begin
            v_idx = (v_first + off) % osw_pkg::NUM_SWITCHES;
            if (!v_found && i_req[v_idx]) begin
                w_grant[v_idx] = 1'b1;
                v_found        = 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_grant       <= '0;
            o_grant_valid <= 1'b0;
        end else begin
            o_grant_valid <= i_req_valid;
            if (i_req_valid) begin
                o_grant <= w_grant;
            end
        end
    end

    // a registered grant goes to exactly one of last cycle's requesters
    a_grant_to_requester: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_grant_valid |-> $onehot0(o_grant)
                          && ((o_grant & ~$past(i_req)) == '0)
                          && ((|o_grant) == (|$past(i_req)))
    );

endmodule

/* src/switch_state.sv */
`timescale 1ns/1ps

module switch_state (
    input  logic                                        i_clk,
    input  logic                                        i_rst,
    input  logic                                        i_init,
    input  logic                                        i_round_start,
    input  osw_pkg::mid_port_t [osw_pkg::NUM_PORTS-1:0] i_mid_port,
    output osw_pkg::sw_vec_t                            o_sw,
    output logic                                        o_conflict_free,
    output osw_pkg::mid_req_t                           o_upper,
    output osw_pkg::mid_req_t                           o_lower
);

    // one request and one grant vector per middle port
    logic [osw_pkg::NUM_MID_PORTS-1:0][osw_pkg::NUM_SWITCHES-1:0] w_req;
    logic [osw_pkg::NUM_MID_PORTS-1:0][osw_pkg::NUM_SWITCHES-1:0] w_grant;
    logic [osw_pkg::NUM_MID_PORTS-1:0]                            w_grant_valid;

    logic [osw_pkg::NUM_SWITCHES-1:0] r_first;
    logic [osw_pkg::NUM_SWITCHES-1:0] w_lose;
    logic [osw_pkg::NUM_SWITCHES-1:0] w_lowest_lose;

    ////////////////////////////////////////
    // middle requests from current modes
    ////////////////////////////////////////

    for (genvar k = 0; k < osw_pkg::NUM_SWITCHES; k++) begin : g_route
        assign o_upper[k*osw_pkg::MID_W +: osw_pkg::MID_W] =
            (o_sw[k] == osw_pkg::SW_BAR) ? i_mid_port[2*k] : i_mid_port[2*k+1];
        assign o_lower[k*osw_pkg::MID_W +: osw_pkg::MID_W] =
            (o_sw[k] == osw_pkg::SW_CROSS) ? i_mid_port[2*k] : i_mid_port[2*k+1];
    end

    // switch k asks port p when its upward input heads there
    for (genvar p = 0; p < osw_pkg::NUM_MID_PORTS; p++) begin : g_port
        for (genvar k = 0; k < osw_pkg::NUM_SWITCHES; k++) begin : g_sw
            assign w_req[p][k] =
                (o_upper[k*osw_pkg::MID_W +: osw_pkg::MID_W] == osw_pkg::mid_port_t'(p));
        end

        port_arbiter u_port_arbiter (
            .i_clk         (i_clk),
            .i_rst         (i_rst),
            .i_req         (w_req[p]),
            .i_first       (r_first),
            .i_req_valid   (i_round_start),
            .o_grant       (w_grant[p]),
            .o_grant_valid (w_grant_valid[p])
        );
    end

    ////////////////////////////////////////
    // loser toggling and priority
    ////////////////////////////////////////

    // modes do not move between request and grant, so w_req still holds
    always_comb begin
        w_lose = '0;
        for (int p = 0; p < osw_pkg::NUM_MID_PORTS; p++) begin
            w_lose = w_lose | (w_req[p] & ~w_grant[p]);
        end
    end

    // isolate the lowest flipped switch
    assign w_lowest_lose = w_lose & (~w_lose + 1'b1);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_sw    <= {osw_pkg::NUM_SWITCHES{osw_pkg::SW_BAR}};
            r_first <= osw_pkg::NUM_SWITCHES'(1);
        end else if (i_init) begin
            o_sw    <= {osw_pkg::NUM_SWITCHES{osw_pkg::SW_BAR}};
            r_first <= osw_pkg::NUM_SWITCHES'(1);
        end else if (&w_grant_valid) begin
            o_sw <= o_sw ^ w_lose;
            if (|w_lose) begin
                r_first <= w_lowest_lose;
            end else begin
                r_first <= osw_pkg::NUM_SWITCHES'(1);
            end
        end
    end

    ////////////////////////////////////////
    // conflict check on upper module
    ////////////////////////////////////////

    always_comb begin
        o_conflict_free = 1'b1;
        for (int i = 0; i < osw_pkg::NUM_SWITCHES; i++) begin
            for (int j = i + 1; j < osw_pkg::NUM_SWITCHES; j++) begin
                if (o_upper[i*osw_pkg::MID_W +: osw_pkg::MID_W]
                    == o_upper[j*osw_pkg::MID_W +: osw_pkg::MID_W]) begin
                    o_conflict_free = 1'b0;
                end
            end
        end
    end

    // a clash on the upper module always costs some switch its port
    a_conflict_flips_switch: assert property (
        @(posedge i_clk) disable iff (i_rst)
        ((&w_grant_valid) && !o_conflict_free) |-> (w_lose != '0)
    );

endmodule

/* src/round_counter.sv */
`timescale 1ns/1ps

module round_counter #(
    parameter int P_MAX_ROUNDS = 8
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_clear,
    input  logic i_step,
    output logic o_at_limit
);

    localparam int CNT_W = $clog2(P_MAX_ROUNDS + 1);

    logic [CNT_W-1:0] r_cnt;

    // saturates at the limit
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_cnt <= '0;
        end else if (i_clear) begin
            r_cnt <= '0;
        end else if (i_step && !o_at_limit) begin
            r_cnt <= r_cnt + 1'b1;
        end
    end

    assign o_at_limit = (r_cnt >= CNT_W'(P_MAX_ROUNDS));

endmodule

/* src/config_fsm.sv */
`timescale 1ns/1ps

module config_fsm (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_req_valid,
    input  logic i_conflict_free,
    input  logic i_at_limit,
    output logic o_capture,
    output logic o_init,
    output logic o_round_start,
    output logic o_clear,
    output logic o_step,
    output logic o_commit,
    output logic o_busy,
    output logic o_cfg_valid,
    output logic o_cfg_error
);

    typedef enum logic [2:0] {
        IDLE,
        CAPTURE,
        CHECK,
        REQUEST,
        UPDATE,
        DONE
    } state_t;

    state_t r_state;
    state_t w_next;

    logic w_ready;
    logic w_finish;

    ////////////////////////////////////////
    // state sequencing
    ////////////////////////////////////////

    // DONE already counts as not busy, so a new request may follow directly
    assign w_ready  = (r_state == IDLE) || (r_state == DONE);
    assign w_finish = i_conflict_free || i_at_limit;

    always_comb begin
        w_next = r_state;
        case (r_state)
            IDLE:    if (i_req_valid) w_next = CAPTURE;
            CAPTURE: w_next = CHECK;
            CHECK:   w_next = w_finish ? DONE : REQUEST;
            REQUEST: w_next = UPDATE;
            UPDATE:  w_next = CHECK;
            DONE:    w_next = i_req_valid ? CAPTURE : IDLE;
            default: w_next = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_state <= IDLE;
        end else begin
            r_state <= w_next;
        end
    end

    // limit hit without a clean upper module
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_cfg_error <= 1'b0;
        end else if (o_commit) begin
            o_cfg_error <= i_at_limit && !i_conflict_free;
        end
    end

    ////////////////////////////////////////
    // strobes
    ////////////////////////////////////////

    assign o_capture     = w_ready && i_req_valid;
    assign o_init        = (r_state == CAPTURE);
    assign o_clear       = (r_state == CAPTURE);
    assign o_round_start = (r_state == REQUEST);
    assign o_step        = (r_state == UPDATE);
    assign o_commit      = (r_state == CHECK) && w_finish;
    assign o_busy        = !w_ready;
    assign o_cfg_valid   = (r_state == DONE);

    a_cfg_valid_pulse: assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_cfg_valid |=> !o_cfg_valid
    );

endmodule

/* src/osw_in_ctrl.sv */
`timescale 1ns/1ps

module osw_in_ctrl #(
    parameter int P_MAX_ROUNDS = 8
) (
    input  logic              i_clk,
    input  logic              i_rst,
    input  osw_pkg::req_vec_t i_req,
    input  logic              i_req_valid,
    output logic              o_busy,
    output logic              o_cfg_valid,
    output logic              o_cfg_error,
    output osw_pkg::sw_vec_t  o_switch_cfg,
    output osw_pkg::mid_req_t o_mid_req_upper,
    output osw_pkg::mid_req_t o_mid_req_lower
);

    logic w_capture;
    logic w_init;
    logic w_round_start;
    logic w_clear;
    logic w_step;
    logic w_commit;
    logic w_conflict_free;
    logic w_at_limit;

    osw_pkg::mid_port_t [osw_pkg::NUM_PORTS-1:0] w_mid_port;
    osw_pkg::sw_vec_t                            w_sw;
    osw_pkg::mid_req_t                           w_upper;
    osw_pkg::mid_req_t                           w_lower;

    route_table u_route_table (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_capture  (w_capture),
        .i_req      (i_req),
        .o_dst      (),
        .o_mid_port (w_mid_port)
    );

    switch_state u_switch_state (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_init          (w_init),
        .i_round_start   (w_round_start),
        .i_mid_port      (w_mid_port),
        .o_sw            (w_sw),
        .o_conflict_free (w_conflict_free),
        .o_upper         (w_upper),
        .o_lower         (w_lower)
    );

    round_counter #(
        .P_MAX_ROUNDS (P_MAX_ROUNDS)
    ) u_round_counter (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_clear    (w_clear),
        .i_step     (w_step),
        .o_at_limit (w_at_limit)
    );

    config_fsm u_config_fsm (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_req_valid     (i_req_valid),
        .i_conflict_free (w_conflict_free),
        .i_at_limit      (w_at_limit),
        .o_capture       (w_capture),
        .o_init          (w_init),
        .o_round_start   (w_round_start),
        .o_clear         (w_clear),
        .o_step          (w_step),
        .o_commit        (w_commit),
        .o_busy          (o_busy),
        .o_cfg_valid     (o_cfg_valid),
        .o_cfg_error     (o_cfg_error)
    );

    // outputs only move at commit, i.e. the edge that raises o_cfg_valid
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_switch_cfg    <= {osw_pkg::NUM_SWITCHES{osw_pkg::SW_BAR}};
            o_mid_req_upper <= '0;
            o_mid_req_lower <= '0;
        end else if (w_commit) begin
            o_switch_cfg    <= w_sw;
            o_mid_req_upper <= w_upper;
            o_mid_req_lower <= w_lower;
        end
    end

endmodule

/* tests/tb_osw_in_ctrl.sv */
`timescale 1ns/1ps

module tb_osw_in_ctrl;

    localparam int WAIT_LIMIT = 200;
    localparam osw_pkg::mid_req_t IDENT_FIELDS = {2'd3, 2'd2, 2'd1, 2'd0};

    logic              i_clk = 1'b0;
    logic              i_rst;
    osw_pkg::req_vec_t i_req;
    logic              i_req_valid;
    logic              o_busy;
    logic              o_cfg_valid;
    logic              o_cfg_error;
    osw_pkg::sw_vec_t  o_switch_cfg;
    osw_pkg::mid_req_t o_mid_req_upper;
    osw_pkg::mid_req_t o_mid_req_lower;

    logic [31:0]       r_lfsr = 32'h8422c331;
    osw_pkg::req_vec_t r_exp_req = '0;
    logic              r_req_seen = 1'b0;
    logic              r_expect_identity = 1'b0;
    logic              r_expect_error = 1'b0;
    logic              r_last_error = 1'b0;
    logic              r_timeout = 1'b0;
    int                r_sent_cnt = 0;
    int                r_cfg_cnt = 0;
    int                r_err_cnt = 0;
    int                r_tests_run = 0;
    int                r_tests_failed = 0;

    osw_in_ctrl #(
        .P_MAX_ROUNDS (8)
    ) u_osw_in_ctrl (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_req           (i_req),
        .i_req_valid     (i_req_valid),
        .o_busy          (o_busy),
        .o_cfg_valid     (o_cfg_valid),
        .o_cfg_error     (o_cfg_error),
        .o_switch_cfg    (o_switch_cfg),
        .o_mid_req_upper (o_mid_req_upper),
        .o_mid_req_lower (o_mid_req_lower)
    );

    always #2 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        if (o_cfg_valid) begin
            r_cfg_cnt <= r_cfg_cnt + 1;
        end
    end

    ////////////////////////////////////////
    // reference model helpers
    ////////////////////////////////////////

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic routing_ok(
        input osw_pkg::req_vec_t req,
        input osw_pkg::sw_vec_t  sw,
        input osw_pkg::mid_req_t up,
        input osw_pkg::mid_req_t lo
    );
        osw_pkg::mid_port_t v_mid [osw_pkg::NUM_PORTS];
        osw_pkg::mid_port_t v_up  [osw_pkg::NUM_SWITCHES];
        osw_pkg::mid_port_t v_lo  [osw_pkg::NUM_SWITCHES];
        logic               v_ok;

        v_ok = 1'b1;
        // two outputs per middle port
        for (int i = 0; i < osw_pkg::NUM_PORTS; i++) begin
            v_mid[i] = osw_pkg::mid_port_t'(req[i*osw_pkg::DST_W +: osw_pkg::DST_W] / 2);
        end
        for (int k = 0; k < osw_pkg::NUM_SWITCHES; k++) begin
            v_up[k] = up[k*osw_pkg::MID_W +: osw_pkg::MID_W];
            v_lo[k] = lo[k*osw_pkg::MID_W +: osw_pkg::MID_W];
            if (sw[k] == osw_pkg::SW_BAR) begin
                v_ok &= (v_up[k] == v_mid[2*k]) && (v_lo[k] == v_mid[2*k+1]);
            end else begin
                v_ok &= (v_up[k] == v_mid[2*k+1]) && (v_lo[k] == v_mid[2*k]);
            end
        end
        for (int i = 0; i < osw_pkg::NUM_SWITCHES; i++) begin
            for (int j = i + 1; j < osw_pkg::NUM_SWITCHES; j++) begin
                if (v_up[i] == v_up[j] || v_lo[i] == v_lo[j]) begin
                    v_ok = 1'b0;
                end
            end
        end
        return v_ok;
    endfunction

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_quiet_after_reset: assert property (@(posedge i_clk) disable iff (i_rst)
        !r_req_seen |-> !o_busy && !o_cfg_valid && !o_cfg_error)
        else begin
            $display("[FAIL] %0t: handshake outputs active before any request", $time);
            r_err_cnt++;
        end

    a_busy_after_accept: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_req_valid && !o_busy) |=> o_busy)
        else begin
            $display("[FAIL] %0t: o_busy did not rise after an accepted request", $time);
            r_err_cnt++;
        end

    a_one_valid_per_request: assert property (@(posedge i_clk) disable iff (i_rst)
        o_cfg_valid |-> (r_cfg_cnt < r_sent_cnt))
        else begin
            $display("[FAIL] %0t: o_cfg_valid without an accepted request", $time);
            r_err_cnt++;
        end

    a_identity_result: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_cfg_valid && r_expect_identity) |-> !o_cfg_error && (o_switch_cfg == '0)
            && (o_mid_req_upper == IDENT_FIELDS) && (o_mid_req_lower == IDENT_FIELDS))
        else begin
            $display("[FAIL] %0t: identity request gave cfg %b upper %h lower %h", $time,
                     o_switch_cfg, o_mid_req_upper, o_mid_req_lower);
            r_err_cnt++;
        end

    a_routing_rules: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_cfg_valid && !o_cfg_error) |->
            routing_ok(r_exp_req, o_switch_cfg, o_mid_req_upper, o_mid_req_lower))
        else begin
            $display("[FAIL] %0t: middle requests upper %h lower %h break routing for cfg %b",
                     $time, o_mid_req_upper, o_mid_req_lower, o_switch_cfg);
            r_err_cnt++;
        end

    a_limit_error: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_cfg_valid && r_expect_error) |-> (o_cfg_error && !o_busy) ##1 !o_busy)
        else begin
            $display("[FAIL] %0t: blocked request did not end with error and idle", $time);
            r_err_cnt++;
        end

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            r_lfsr = lfsr_step(r_lfsr);
            val    = {val[30:0], r_lfsr[0]};
        end
    endtask

    // fisher-yates over the eight outputs
    task automatic make_permutation(output osw_pkg::req_vec_t req);
        int          v_perm [osw_pkg::NUM_PORTS];
        int          v_j;
        int          v_tmp;
        logic [31:0] v_bits;

        for (int i = 0; i < osw_pkg::NUM_PORTS; i++) begin
            v_perm[i] = i;
        end
        for (int i = osw_pkg::NUM_PORTS - 1; i > 0; i--) begin
            take_bits(osw_pkg::DST_W, v_bits);
            v_j       = v_bits % (i + 1);
            v_tmp     = v_perm[i];
            v_perm[i] = v_perm[v_j];
            v_perm[v_j] = v_tmp;
        end
        for (int i = 0; i < osw_pkg::NUM_PORTS; i++) begin
            req[i*osw_pkg::DST_W +: osw_pkg::DST_W] = osw_pkg::dst_t'(v_perm[i]);
        end
    endtask

    task automatic send_request(input osw_pkg::req_vec_t req);
        r_exp_req   = req;
        r_req_seen  = 1'b1;
        r_sent_cnt++;
        i_req       = req;
        i_req_valid = 1'b1;
        @(posedge i_clk);
        #1;
        i_req_valid = 1'b0;
    endtask

    task automatic wait_cfg_valid(input string what);
        int v_cycles;

        v_cycles = 0;
        while (!o_cfg_valid && v_cycles < WAIT_LIMIT) begin
            @(posedge i_clk);
            #1;
            v_cycles++;
        end
        if (!o_cfg_valid) begin
            $display("timeout: no o_cfg_valid within %0d cycles during %s", WAIT_LIMIT, what);
            r_timeout = 1'b1;
        end else begin
            r_last_error = o_cfg_error;
            // let the checks on the pulse and the cycle after it run
            for (int c = 0; c < 2; c++) begin
                @(posedge i_clk);
                #1;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        r_tests_run++;
        if (r_err_cnt == errs_before && !r_timeout) begin
            $display("test %0d, %s: ok", r_tests_run, name);
        end else begin
            r_tests_failed++;
            $display("test %0d, %s: failed", r_tests_run, name);
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        osw_pkg::req_vec_t v_req;
        int                v_errs;
        int                v_limit_hits;
        int                v_cycles;

        i_rst       = 1'b1;
        i_req       = '0;
        i_req_valid = 1'b0;
        repeat (4) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        v_errs = r_err_cnt;
        repeat (6) @(posedge i_clk);
        #1;
        finish_test("quiet after reset", v_errs);

        v_errs = r_err_cnt;
        for (int i = 0; i < osw_pkg::NUM_PORTS; i++) begin
            v_req[i*osw_pkg::DST_W +: osw_pkg::DST_W] = osw_pkg::dst_t'(i);
        end
        r_expect_identity = 1'b1;
        send_request(v_req);
        wait_cfg_valid("identity request");
        r_expect_identity = 1'b0;
        finish_test("identity request", v_errs);

        v_errs       = r_err_cnt;
        v_limit_hits = 0;
        for (int n = 0; n < 30; n++) begin
            make_permutation(v_req);
            send_request(v_req);
            wait_cfg_valid("random permutation");
            if (r_last_error) begin
                v_limit_hits++;
            end
        end
        finish_test($sformatf("30 permutations, %0d at round limit", v_limit_hits), v_errs);

        // every input on port 0 can never clear the upper module
        v_errs         = r_err_cnt;
        r_expect_error = 1'b1;
        send_request('0);
        wait_cfg_valid("blocked request");
        r_expect_error = 1'b0;
        finish_test("round limit error", v_errs);

        v_errs = r_err_cnt;
        make_permutation(v_req);
        send_request(v_req);
        v_cycles = 0;
        while (!o_busy && v_cycles < WAIT_LIMIT) begin
            @(posedge i_clk);
            #1;
            v_cycles++;
        end
        if (!o_busy) begin
            $display("timeout: o_busy never rose after the first request");
            r_timeout = 1'b1;
        end
        i_req       = '0;
        i_req_valid = 1'b1;
        @(posedge i_clk);
        #1;
        i_req_valid = 1'b0;
        wait_cfg_valid("request while busy");
        repeat (40) @(posedge i_clk);
        #1;
        finish_test("request while busy ignored", v_errs);

        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 r_tests_run, r_tests_run - r_tests_failed, r_tests_failed, r_err_cnt);
        if (r_tests_failed == 0 && r_err_cnt == 0 && !r_timeout) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb.f */
src/osw_pkg.sv
src/route_table.sv
src/port_arbiter.sv
src/switch_state.sv
src/round_counter.sv
src/config_fsm.sv
src/osw_in_ctrl.sv
tests/tb_osw_in_ctrl.sv

/* Bender.yml */
package:
  name: osw_in_ctrl

sources:
  - src/osw_pkg.sv
  - src/route_table.sv
  - src/port_arbiter.sv
  - src/switch_state.sv
  - src/round_counter.sv
  - src/config_fsm.sv
  - src/osw_in_ctrl.sv
  - target: test
    files:
      - tests/tb_osw_in_ctrl.sv
